// ==== hw/coram_macros.svh ====
/*
 * Width and depth macros for the CoRAM channel queues
 */
`ifndef CORAM_MACROS_SVH
`define CORAM_MACROS_SVH

// --------------------
// Data path
// --------------------

// Bits in one data word
`define CORAM_DATA_WIDTH 32

// --------------------
// Queue sizing
// --------------------

// Depth is 2**ADDR_LEN, one slot stays free
`define CORAM_ADDR_LEN 4

`endif

// ==== hw/coram_pkg.sv ====
/*
 * Payload and status types shared by the channel queues
 */
`include "coram_macros.svh"

package coram_pkg;

  // Plain data word
  typedef logic [`CORAM_DATA_WIDTH-1:0] word_t;

  // Outgoing beat, last marks the end of a burst
  typedef struct packed {
    word_t data;
    logic  last;
  } out_beat_t;

  // Enqueue side flags
  typedef struct packed {
    logic full;
    logic alm_full;
  } enq_status_t;

  // Dequeue side flags
  typedef struct packed {
    logic empty;
    logic alm_empty;
  } deq_status_t;

  // Free entries, wide enough for the full capacity
  typedef logic [`CORAM_ADDR_LEN:0] room_t;

endpackage

// ==== hw/coram_dp_bram.sv ====
/*
 * Dual-port block RAM, one write port and one read port
 * with a registered read address
 */
`timescale 1ns/10ps
`include "coram_macros.svh"

module coram_dp_bram
  import coram_pkg::*;
#(
  parameter type payload_t = word_t,
  parameter int  ADDR_LEN  = `CORAM_ADDR_LEN
) (
  input  logic                CLK0,
  input  logic [ADDR_LEN-1:0] wr_addr,
  input  payload_t            wr_data,
  input  logic                wr_en,
  input  logic [ADDR_LEN-1:0] rd_addr,
  output payload_t            rd_data
);

  localparam int DEPTH = 2 ** ADDR_LEN;

  payload_t            mem [0:DEPTH-1];
  logic [ADDR_LEN-1:0] rd_addr_q;

  // Write port and read address latch
  always_ff @(posedge CLK0) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_addr_q <= rd_addr;
  end

  // Array read through the latched address, new data shows right after a write
  assign rd_data = mem[rd_addr_q];

  // --------------------
  // Checks
  // --------------------
  a_wr_addr_known: assert property (@(posedge CLK0)
    wr_en |-> !$isunknown(wr_addr))
    else $error("RAM write issued with an unknown address");

endmodule

// ==== hw/coram_fifo_ctrl.sv ====
/*
 * Queue control: wrapping head and tail pointers,
 * registered full and empty flags, enqueue room count
 */
`timescale 1ns/10ps
`include "coram_macros.svh"

module coram_fifo_ctrl
  import coram_pkg::*;
#(
  parameter int ADDR_LEN = `CORAM_ADDR_LEN
) (
  input  logic                CLK0,
  input  logic                RST0,
  input  logic                enq,
  input  logic                deq,
  output logic [ADDR_LEN-1:0] wr_addr,
  output logic [ADDR_LEN-1:0] rd_addr,
  output logic                wr_en,
  output enq_status_t         enq_stat,
  output deq_status_t         deq_stat,
  output room_t               room
);

  // One slot is kept free so equal pointers mean empty
  localparam int DEPTH = 2 ** ADDR_LEN;
  localparam int CAP   = DEPTH - 1;

  logic [ADDR_LEN-1:0] head;
  logic [ADDR_LEN-1:0] tail;
  logic [ADDR_LEN-1:0] head_nxt;
  logic [ADDR_LEN-1:0] tail_nxt;
  logic [ADDR_LEN-1:0] count_nxt;
  logic                accept;
  logic                remove;

  // --------------------
  // Next state
  // --------------------

  // Requests against a full or empty queue are dropped
  assign accept = enq && !enq_stat.full;
  assign remove = deq && !deq_stat.empty;

  // Pointers wrap at DEPTH through the natural overflow
  assign tail_nxt  = accept ? tail + 1'b1 : tail;
  assign head_nxt  = remove ? head + 1'b1 : head;
  assign count_nxt = tail_nxt - head_nxt;

  // RAM side
  assign wr_en   = accept;
  assign wr_addr = tail;
  // Next head so the RAM latch already points at the new oldest entry
  assign rd_addr = head_nxt;

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= head_nxt;
      tail <= tail_nxt;
    end
  end

  // Flags follow the entry count after this edge
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      deq_stat.empty     <= 1'b1;
      deq_stat.alm_empty <= 1'b1;
      enq_stat.full      <= 1'b0;
      enq_stat.alm_full  <= 1'b0;
      room               <= room_t'(CAP);
    end else begin
      deq_stat.empty     <= (count_nxt == '0);
      deq_stat.alm_empty <= (count_nxt <= ADDR_LEN'(1));
      enq_stat.full      <= (count_nxt == ADDR_LEN'(CAP));
      enq_stat.alm_full  <= (count_nxt >= ADDR_LEN'(CAP - 1));
      room               <= room_t'(CAP) - room_t'(count_nxt);
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Tail is frozen for the edge after full is seen
  a_tail_hold_full: assert property (@(posedge CLK0) disable iff (RST0)
    enq_stat.full |=> $stable(tail))
    else $error("tail pointer moved while the queue was full");

  // Head is frozen for the edge after empty is seen
  a_head_hold_empty: assert property (@(posedge CLK0) disable iff (RST0)
    deq_stat.empty |=> $stable(head))
    else $error("head pointer moved while the queue was empty");

  a_full_empty_excl: assert property (@(posedge CLK0) disable iff (RST0)
    !(enq_stat.full && deq_stat.empty))
    else $error("queue reported full and empty at the same time");

endmodule

// ==== hw/coram_bram_fifo.sv ====
/*
 * Non-transparent FIFO, pointer control on top of a dual-port block RAM
 */
`timescale 1ns/10ps
`include "coram_macros.svh"

module coram_bram_fifo
  import coram_pkg::*;
#(
  parameter type payload_t = word_t,
  parameter int  ADDR_LEN  = `CORAM_ADDR_LEN
) (
  input  logic        CLK0,
  input  logic        RST0,
  // Enqueue side
  input  payload_t    d,
  input  logic        enq,
  output enq_status_t enq_stat,
  // Dequeue side
  output payload_t    q,
  input  logic        deq,
  output deq_status_t deq_stat,
  output room_t       room
);

  logic [ADDR_LEN-1:0] wr_addr;
  logic [ADDR_LEN-1:0] rd_addr;
  logic                wr_en;

  // Pointers and flags
  coram_fifo_ctrl #(
    .ADDR_LEN (ADDR_LEN)
  ) ctrl (
    .CLK0     (CLK0),
    .RST0     (RST0),
    .enq      (enq),
    .deq      (deq),
    .wr_addr  (wr_addr),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .enq_stat (enq_stat),
    .deq_stat (deq_stat),
    .room     (room)
  );

  // Storage, written at the tail and read at the head
  coram_dp_bram #(
    .payload_t (payload_t),
    .ADDR_LEN  (ADDR_LEN)
  ) ram (
    .CLK0    (CLK0),
    .wr_addr (wr_addr),
    .wr_data (d),
    .wr_en   (wr_en),
    .rd_addr (rd_addr),
    .rd_data (q)
  );

endmodule

// ==== hw/coram_channel.sv ====
/*
 * CoRAM channel, an outgoing queue from user logic to the control side
 * and an incoming queue back to user logic
 */
`timescale 1ns/10ps
`include "coram_macros.svh"

module coram_channel
  import coram_pkg::*;
(
  input  logic        CLK0,
  input  logic        RST0,
  // User side
  input  out_beat_t   d,
  input  logic        enq,
  output enq_status_t enq_stat,
  output word_t       q,
  input  logic        deq,
  output deq_status_t deq_stat,
  // Control side
  output out_beat_t   coram_q,
  input  logic        coram_deq,
  output deq_status_t coram_deq_stat,
  input  word_t       coram_d,
  input  logic        coram_enq,
  output enq_status_t coram_enq_stat,
  output room_t       coram_room
);

  // --------------------
  // User to control
  // --------------------

  // Room on the user side is not exported
  coram_bram_fifo #(
    .payload_t (out_beat_t),
    .ADDR_LEN  (`CORAM_ADDR_LEN)
  ) out_fifo (
    .CLK0     (CLK0),
    .RST0     (RST0),
    .d        (d),
    .enq      (enq),
    .enq_stat (enq_stat),
    .q        (coram_q),
    .deq      (coram_deq),
    .deq_stat (coram_deq_stat),
    .room     ()
  );

  // --------------------
  // Control to user
  // --------------------
  coram_bram_fifo #(
    .payload_t (word_t),
    .ADDR_LEN  (`CORAM_ADDR_LEN)
  ) in_fifo (
    .CLK0     (CLK0),
    .RST0     (RST0),
    .d        (coram_d),
    .enq      (coram_enq),
    .enq_stat (coram_enq_stat),
    .q        (q),
    .deq      (deq),
    .deq_stat (deq_stat),
    .room     (coram_room)
  );

endmodule

// ==== verification/tb_channel_model.svh ====
/*
 * Random generator, reference queue models and output checks
 * for the channel testbench
 */
`ifndef TB_CHANNEL_MODEL_SVH
`define TB_CHANNEL_MODEL_SVH

// --------------------
// Random numbers
// --------------------
logic [31:0] rng_state = SEED;

function automatic logic [31:0] lcg_next();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;
  return rng_state;
endfunction

// True on roughly pct out of 100 calls
function automatic bit chance(input int pct);
  logic [31:0] r;
  r = lcg_next();
  return ((r >> 8) % 100) < pct;
endfunction

// --------------------
// Reference queues
// --------------------
out_beat_t out_model[$];
word_t     in_model[$];

task automatic update_models();
  int out_n;
  int in_n;
  bit out_acc;
  bit out_rem;
  bit in_acc;
  bit in_rem;
  out_n   = out_model.size();
  in_n    = in_model.size();
  out_acc = enq && (out_n < CAP);
  out_rem = coram_deq && (out_n > 0);
  in_acc  = coram_enq && (in_n < CAP);
  in_rem  = deq && (in_n > 0);
  // Refused enqueues are lost, nothing is recorded
  if (enq && !out_acc) drops_out++;
  if (coram_enq && !in_acc) drops_in++;
  if (out_acc && out_rem && out_n >= 6 && out_n <= 9) mid_pairs++;
  if (in_acc && in_rem && in_n >= 6 && in_n <= 9) mid_pairs++;
  if (out_rem) void'(out_model.pop_front());
  if (out_acc) out_model.push_back(d);
  if (in_rem) void'(in_model.pop_front());
  if (in_acc) in_model.push_back(coram_d);
endtask

// --------------------
// Checks
// --------------------
task automatic report_value(input string what, input logic [63:0] exp,
                            input logic [63:0] act);
  errors++;
  $display("[ERROR] %s %s: expected 'h%0h, actual 'h%0h", test_name, what, exp, act);
endtask

task automatic check_outgoing();
  int n;
  n = out_model.size();
  if (coram_deq_stat.empty !== (n == 0))
    report_value("out empty", n == 0, coram_deq_stat.empty);
  if (coram_deq_stat.alm_empty !== (n <= 1))
    report_value("out almost-empty", n <= 1, coram_deq_stat.alm_empty);
  if (enq_stat.full !== (n == CAP))
    report_value("out full", n == CAP, enq_stat.full);
  if (enq_stat.alm_full !== (n >= CAP - 1))
    report_value("out almost-full", n >= CAP - 1, enq_stat.alm_full);
  if (n > 0 && coram_q !== out_model[0])
    report_value("out beat", out_model[0], coram_q);
endtask

task automatic check_incoming();
  int n;
  n = in_model.size();
  if (deq_stat.empty !== (n == 0))
    report_value("in empty", n == 0, deq_stat.empty);
  if (deq_stat.alm_empty !== (n <= 1))
    report_value("in almost-empty", n <= 1, deq_stat.alm_empty);
  if (coram_enq_stat.full !== (n == CAP))
    report_value("in full", n == CAP, coram_enq_stat.full);
  if (coram_enq_stat.alm_full !== (n >= CAP - 1))
    report_value("in almost-full", n >= CAP - 1, coram_enq_stat.alm_full);
  if (coram_room !== room_t'(CAP - n))
    report_value("in room", CAP - n, coram_room);
  if (n > 0 && q !== in_model[0])
    report_value("in word", in_model[0], q);
endtask

`endif

// ==== verification/tb_coram_channel.sv ====
/*
 * Testbench for the CoRAM channel: random traffic on both queues
 * checked against reference models, watchdog and closing report
 */
`timescale 1ns/10ps
`include "coram_macros.svh"

module tb_coram_channel
  import coram_pkg::*;
;

  localparam logic [31:0] SEED         = 32'ha991;
  localparam int          PERIOD_NS    = 4;
  localparam int          PHASE_CYCLES = 400;
  localparam int          CAP          = 2 ** `CORAM_ADDR_LEN - 1;
  // Four phases plus reset and a margin
  localparam int          TIMEOUT_NS   = (4 * PHASE_CYCLES + 3 + 100) * PERIOD_NS;

  logic        CLK0;
  logic        RST0;

  // User side
  out_beat_t   d;
  logic        enq;
  enq_status_t enq_stat;
  word_t       q;
  logic        deq;
  deq_status_t deq_stat;

  // Control side
  out_beat_t   coram_q;
  logic        coram_deq;
  deq_status_t coram_deq_stat;
  word_t       coram_d;
  logic        coram_enq;
  enq_status_t coram_enq_stat;
  room_t       coram_room;

  int    errors    = 0;
  int    drops_out = 0;
  int    drops_in  = 0;
  int    mid_pairs = 0;
  string test_name = "init";

  `include "tb_channel_model.svh"

  coram_channel uut (
    .CLK0           (CLK0),
    .RST0           (RST0),
    .d              (d),
    .enq            (enq),
    .enq_stat       (enq_stat),
    .q              (q),
    .deq            (deq),
    .deq_stat       (deq_stat),
    .coram_q        (coram_q),
    .coram_deq      (coram_deq),
    .coram_deq_stat (coram_deq_stat),
    .coram_d        (coram_d),
    .coram_enq      (coram_enq),
    .coram_enq_stat (coram_enq_stat),
    .coram_room     (coram_room)
  );

  always #2 CLK0 = ~CLK0;

  // --------------------
  // Stimulus
  // --------------------

  // With hold_mid the fill level is steered into 6..9 where both sides run
  task automatic choose_inputs(input int enq_pct, input int deq_pct, input bit hold_mid);
    logic [31:0] r;
    int out_n;
    int in_n;
    out_n   = out_model.size();
    in_n    = in_model.size();
    r       = lcg_next();
    d.data  = lcg_next();
    d.last  = r[31];
    coram_d = lcg_next();
    if (hold_mid) begin
      enq       = out_n < 6 || (out_n <= 9 && chance(enq_pct));
      coram_deq = out_n > 9 || (out_n >= 6 && chance(deq_pct));
      coram_enq = in_n < 6 || (in_n <= 9 && chance(enq_pct));
      deq       = in_n > 9 || (in_n >= 6 && chance(deq_pct));
    end else begin
      enq       = chance(enq_pct);
      coram_deq = chance(deq_pct);
      coram_enq = chance(enq_pct);
      deq       = chance(deq_pct);
    end
  endtask

  // One cycle per pass, checks land 1 ns after the edge
  task automatic run_phase(input string name, input int enq_pct, input int deq_pct,
                           input bit hold_mid);
    test_name = name;
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      choose_inputs(enq_pct, deq_pct, hold_mid);
      @(posedge CLK0);
      update_models();
      #1;
      check_outgoing();
      check_incoming();
    end
  endtask

  initial begin
    CLK0      = 1'b0;
    RST0      = 1'b1;
    d         = '0;
    enq       = 1'b0;
    deq       = 1'b0;
    coram_deq = 1'b0;
    coram_d   = '0;
    coram_enq = 1'b0;
    repeat (3) @(posedge CLK0);
    #1;
    RST0 = 1'b0;

    test_name = "reset";
    check_outgoing();
    check_incoming();

    run_phase("random traffic", 50, 50, 1'b0);
    // Consumers stalled, both queues fill and refuse
    run_phase("back-pressure fill", 90, 0, 1'b0);
    run_phase("drain", 20, 80, 1'b0);
    run_phase("mid-level enq and deq", 85, 85, 1'b1);

    if (drops_out == 0) begin
      errors++;
      $display("No enqueue was refused while the outgoing queue was full");
    end
    if (drops_in == 0) begin
      errors++;
      $display("No enqueue was refused while the incoming queue was full");
    end
    if (mid_pairs == 0) begin
      errors++;
      $display("No simultaneous enqueue and dequeue happened at a middle fill level");
    end

    $display("Closing report: %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hw
+incdir+verification
hw/coram_pkg.sv
hw/coram_dp_bram.sv
hw/coram_fifo_ctrl.sv
hw/coram_bram_fifo.sv
hw/coram_channel.sv
verification/tb_coram_channel.sv

// ==== Bender.yml ====
package:
  name: coram_channel

sources:
  - include_dirs:
      - hw
    files:
      - hw/coram_pkg.sv
      - hw/coram_dp_bram.sv
      - hw/coram_fifo_ctrl.sv
      - hw/coram_bram_fifo.sv
      - hw/coram_channel.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/tb_coram_channel.sv
